// ==== all.f ====
+incdir+hw
hw/oisc_pkg.sv
hw/rv_decoder.sv
hw/reg_bank.sv
hw/subleq_engine.sv
hw/oisc_control.sv
hw/oisc_top.sv
bench/tb_clock.sv
bench/tb_oisc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := tb_oisc
FILELIST  := all.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Something failed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_oisc.sv ====
// Bench for oisc_top running a random straight-line program of ADD, SUB, ADDI, LW and SW
// Memory answers with 0 to 3 wait states; requests are checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module tb_oisc
   import oisc_pkg::*;
();

   localparam word_t NOP        = 32'h0000_0013;   // ADDI x0, x0, 0
   localparam int    N_RAND     = 24;
   localparam int    CYC_PER_OP = 60;

   typedef struct packed {
      logic  fetch;
      logic  we;
      word_t adr;
      word_t dat;
   } bus_req_t;

   logic        clk;
   logic        rst_n;
   logic        wb_ack = 1'b0;
   word_t       wb_dat = '0;
   wb_req_t     wb;
   logic [31:0] lfsr = 32'h33de_874a;
   word_t       prog [$];
   word_t       data_mem [word_t];   // What the bus sees
   word_t       ref_mem [word_t];    // What the reference model expects
   word_t       ref_x [32];
   bus_req_t    exp_q [$];           // Every request of the core, in order
   bus_req_t    cur_exp = '0;
   int          n_req = 0;
   int          req_idx = 0;
   word_t       last_fetch = '0;
   int          mismatch_cnt = 0;
   int          other_cnt = 0;
   int          delay = 0;
   logic        waiting = 1'b0;

   tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(2)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

   oisc_top #(.ROM_DEPTH(256)) dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_ack_i (wb_ack),
      .wb_dat_i (wb_dat),
      .wb_o     (wb)
   );

   // ------------------------------------------------------------
   // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1

   function automatic word_t next_bits(int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic word_t fill_word(word_t adr);
      return (adr * 32'h9E37_79B1) ^ 32'hA5C3_0F69;   // Words never written
   endfunction

   function automatic word_t read_word(word_t adr);
      int idx;
      idx = int'((adr - RESET_PC) >> 2);
      if (adr >= RESET_PC) begin
         return (idx < prog.size()) ? prog[idx] : NOP;
      end
      return data_mem.exists(adr) ? data_mem[adr] : fill_word(adr);
   endfunction

   // ------------------------------------------------------------
   // Program builder and reference model

   task automatic expect_req(logic fetch, logic we, word_t adr, word_t dat);
      bus_req_t r;
      r.fetch = fetch;
      r.we    = we;
      r.adr   = adr;
      r.dat   = dat;
      exp_q.push_back(r);
   endtask

   task automatic emit(word_t instr);
      expect_req(1'b1, 1'b0, RESET_PC + (word_t'(prog.size()) << 2), '0);
      prog.push_back(instr);
   endtask

   task automatic rtype_instr(rv_idx_t rd, rv_idx_t rs1, rv_idx_t rs2, logic sub);
      emit({1'b0, sub, 5'd0, rs2, rs1, 3'b000, rd, OPC_OP});
      if (rd != 5'd0) begin
         ref_x[rd] = sub ? ref_x[rs1] - ref_x[rs2] : ref_x[rs1] + ref_x[rs2];
      end
   endtask

   task automatic addi_instr(rv_idx_t rd, rv_idx_t rs1, logic [11:0] imm);
      emit({imm, rs1, 3'b000, rd, OPC_OP_IMM});
      if (rd != 5'd0) begin
         ref_x[rd] = ref_x[rs1] + {{20{imm[11]}}, imm};
      end
   endtask

   task automatic lw_instr(rv_idx_t rd, rv_idx_t rs1, logic [11:0] imm);
      word_t adr;
      adr = ref_x[rs1] + {{20{imm[11]}}, imm};
      emit({imm, rs1, 3'b010, rd, OPC_LOAD});
      expect_req(1'b0, 1'b0, adr, '0);
      if (rd != 5'd0) begin
         ref_x[rd] = ref_mem.exists(adr) ? ref_mem[adr] : fill_word(adr);
      end
   endtask

   task automatic sw_instr(rv_idx_t rs2, rv_idx_t rs1, logic [11:0] imm);
      word_t adr;
      adr = ref_x[rs1] + {{20{imm[11]}}, imm};
      emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
      expect_req(1'b0, 1'b1, adr, ref_x[rs2]);
      ref_mem[adr] = ref_x[rs2];
   endtask

   task automatic build_program();
      rv_idx_t     rd;
      rv_idx_t     rs1;
      rv_idx_t     rs2;
      logic [1:0]  op;
      logic [11:0] imm;
      for (int r = 0; r < 32; r++) begin
         ref_x[r] = '0;
      end
      for (int r = 1; r < 8; r++) begin
         imm = 12'(next_bits(12));
         addi_instr(rv_idx_t'(r), 5'd0, imm);
      end
      addi_instr(5'd8, 5'd0, 12'h100);   // x8 holds the data base and stays out of the random set
      for (int k = 0; k < N_RAND; k++) begin
         op  = 2'(next_bits(2));
         rd  = rv_idx_t'(next_bits(3));
         rs1 = rv_idx_t'(next_bits(3));
         rs2 = rv_idx_t'(next_bits(3));
         imm = 12'(next_bits(12));
         if (op[1]) begin
            addi_instr(rd, rs1, imm);
         end else begin
            rtype_instr(rd, rs1, rs2, op[0]);
         end
         if (k % 3 == 2) begin
            sw_instr(rd, 5'd8, 12'(32 + 4 * k));
         end
      end
      for (int i = 1; i < 8; i++) begin
         sw_instr(rv_idx_t'(i), 5'd8, 12'(4 * i));
      end
      // Reload in reverse order, then store each copy to a second slot
      for (int i = 1; i < 8; i++) begin
         lw_instr(rv_idx_t'(8 - i), 5'd8, 12'(4 * i));
         sw_instr(rv_idx_t'(8 - i), 5'd8, 12'(128 + 4 * i));
      end
      lw_instr(5'd3, 5'd8, 12'h0C0);      // Never written, fill pattern
      sw_instr(5'd3, 5'd8, 12'h0C4);
      rtype_instr(5'd0, 5'd1, 5'd2, 1'b0);
      sw_instr(5'd0, 5'd8, 12'h0F0);
      addi_instr(5'd0, 5'd5, 12'h7FF);
      sw_instr(5'd0, 5'd8, 12'h0F4);
      for (int i = 0; i < 3; i++) begin
         emit(NOP);                        // Memory keeps answering NOP past the end
      end
      n_req   = exp_q.size();
      cur_exp <= exp_q[0];
   endtask

   // ------------------------------------------------------------
   // Wishbone memory acting on the falling edge

   always @(negedge clk) begin
      if (!rst_n) begin
         wb_ack  <= 1'b0;
         waiting = 1'b0;
      end else if (wb_ack) begin
         wb_ack <= 1'b0;                  // Transfer ended at the last rising edge
         if (cur_exp.fetch) begin
            last_fetch <= cur_exp.adr;
         end
         if (req_idx + 1 < n_req) begin
            cur_exp <= exp_q[req_idx + 1];
         end
         req_idx <= req_idx + 1;
      end else if (wb.stb) begin
         if (!waiting) begin
            delay   = int'(next_bits(2));  // 0 to 3 wait states
            waiting = 1'b1;
         end
         if (delay == 0) begin
            wb_ack  <= 1'b1;
            wb_dat  <= read_word(wb.adr);
            waiting = 1'b0;
            if (wb.we) begin
               data_mem[wb.adr] = wb.dat;
            end
         end else begin
            delay--;
         end
      end
   end

   // ------------------------------------------------------------
   // Checks

   a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !wb.stb)
      else begin
         other_cnt++;
         $display("%0t: bus request raised while in reset", $time);
      end

   a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb.stb)
      else begin
         other_cnt++;
         $display("%0t: request in the first cycle after reset", $time);
      end

   a_first_req: assert property (@(posedge clk) $rose(rst_n) |=> wb.stb)
      else begin
         other_cnt++;
         $display("%0t: no request in the second cycle after reset", $time);
      end

   a_cyc_stb: assert property (@(posedge clk) wb.cyc == wb.stb)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t wb_o.cyc got %b expected %b", $time,
                  $sampled(wb.cyc), $sampled(wb.stb));
      end

   a_sel_word: assert property (@(posedge clk) disable iff (!rst_n)
      wb.stb |-> wb.sel == 4'hF)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t wb_o.sel got %h expected %h", $time,
                  $sampled(wb.sel), 4'hF);
      end

   a_req_we: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.stb && req_idx < n_req) |-> wb.we == cur_exp.we)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t wb_o.we got %b expected %b", $time,
                  $sampled(wb.we), $sampled(cur_exp.we));
      end

   a_req_adr: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.stb && req_idx < n_req) |-> wb.adr == cur_exp.adr)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t wb_o.adr got %h expected %h", $time,
                  $sampled(wb.adr), $sampled(cur_exp.adr));
      end

   a_store_dat: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.stb && req_idx < n_req && cur_exp.we) |-> wb.dat == cur_exp.dat)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t wb_o.dat got %h expected %h", $time,
                  $sampled(wb.dat), $sampled(cur_exp.dat));
      end

   a_fetch_step: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.stb && cur_exp.fetch && req_idx > 0 && req_idx < n_req) |->
      wb.adr == last_fetch + 32'd4)
      else begin
         mismatch_cnt++;
         $display("MISMATCH %0t fetch wb_o.adr got %h expected %h", $time,
                  $sampled(wb.adr), $sampled(last_fetch) + 32'd4);
      end

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.dat)
                               && $stable(wb.we)))
      else begin
         other_cnt++;
         $display("%0t: request dropped or changed while waiting for ack", $time);
      end

   // ------------------------------------------------------------
   // Run control

   initial begin
      build_program();
      wait (rst_n && req_idx == n_req);
      repeat (4) @(posedge clk);
      $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      @(posedge rst_n);
      repeat (prog.size() * CYC_PER_OP) @(posedge clk);
      $display("Timeout: %0d of %0d bus requests seen, %0d mismatches, %0d other errors",
               req_idx, n_req, mismatch_cnt, other_cnt);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Free running clock and active low reset for the bench
// Reset is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 2
)(
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;   // Away from the sampling edge
   end

endmodule

`default_nettype wire

// ==== hw/oisc_top.sv ====
// RV32I subset core built on a SUBLEQ microcode engine, classic Wishbone master
// ROM_DEPTH sizes the micro program counter check in the engine
`timescale 1ns/100ps
`default_nettype none

module oisc_top
   import oisc_pkg::*;
#(
   parameter int ROM_DEPTH = 256
)(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        wb_ack_i,
   input  wire word_t wb_dat_i,
   output wb_req_t    wb_o
);

   dec_t       dec;
   logic       dec_load;
   reg_idx_t   reg_ra;
   reg_idx_t   reg_rb;
   reg_idx_t   reg_wa;
   logic       reg_we;
   word_t      reg_wdata;
   word_t      reg_a;
   word_t      reg_b;
   logic       eng_start;
   micro_idx_t eng_ra;
   micro_idx_t eng_rb;
   logic       eng_wb_en;
   micro_idx_t eng_wb_idx;
   word_t      eng_wb_val;
   logic       eng_done;
   word_t      eng_result;

   oisc_control u_control (
      .clk          (clk),
      .rst_n        (rst_n),
      .wb_ack_i     (wb_ack_i),
      .wb_dat_i     (wb_dat_i),
      .wb_o         (wb_o),
      .dec_i        (dec),
      .dec_load_o   (dec_load),
      .reg_ra_o     (reg_ra),
      .reg_rb_o     (reg_rb),
      .reg_wa_o     (reg_wa),
      .reg_we_o     (reg_we),
      .reg_wdata_o  (reg_wdata),
      .reg_a_i      (reg_a),
      .reg_b_i      (reg_b),
      .eng_start_o  (eng_start),
      .eng_ra_i     (eng_ra),
      .eng_rb_i     (eng_rb),
      .eng_wb_en_i  (eng_wb_en),
      .eng_wb_idx_i (eng_wb_idx),
      .eng_wb_val_i (eng_wb_val),
      .eng_done_i   (eng_done),
      .eng_result_i (eng_result)
   );

   rv_decoder u_decoder (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr_i (wb_dat_i),   // Fetch data straight from the bus
      .load_i  (dec_load),
      .dec_o   (dec)
   );

   reg_bank u_reg_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .ra_i    (reg_ra),
      .rb_i    (reg_rb),
      .wa_i    (reg_wa),
      .we_i    (reg_we),
      .wdata_i (reg_wdata),
      .a_o     (reg_a),
      .b_o     (reg_b)
   );

   subleq_engine #(
      .ROM_DEPTH (ROM_DEPTH)
   ) u_engine (
      .clk      (clk),
      .rst_n    (rst_n),
      .start_i  (eng_start),
      .entry_i  (dec.entry),
      .a_i      (reg_a),
      .b_i      (reg_b),
      .ra_o     (eng_ra),
      .rb_o     (eng_rb),
      .wb_en_o  (eng_wb_en),
      .wb_idx_o (eng_wb_idx),
      .wb_val_o (eng_wb_val),
      .done_o   (eng_done),
      .result_o (eng_result)
   );

endmodule

`default_nettype wire

// ==== hw/oisc_control.sv ====
// Instruction phase machine and classic Wishbone master with one instruction in flight
// The slave may stretch FETCH_INSTR and MEMORY by holding ack low
`timescale 1ns/100ps
`default_nettype none

module oisc_control
   import oisc_pkg::*;
(
   input  wire             clk,
   input  wire             rst_n,

   input  wire             wb_ack_i,
   input  wire word_t      wb_dat_i,
   output wb_req_t         wb_o,

   input  wire dec_t       dec_i,
   output logic            dec_load_o,

   output reg_idx_t        reg_ra_o,
   output reg_idx_t        reg_rb_o,
   output reg_idx_t        reg_wa_o,
   output logic            reg_we_o,
   output word_t           reg_wdata_o,
   input  wire word_t      reg_a_i,
   input  wire word_t      reg_b_i,

   output logic            eng_start_o,
   input  wire micro_idx_t eng_ra_i,
   input  wire micro_idx_t eng_rb_i,
   input  wire             eng_wb_en_i,
   input  wire micro_idx_t eng_wb_idx_i,
   input  wire word_t      eng_wb_val_i,
   input  wire             eng_done_i,
   input  wire word_t      eng_result_i
);

   rv_phase_e phase_q;
   word_t     adr_q;      // Fetch address, then load or store address
   word_t     st_dat_q;   // rs2 value for SW

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase_q <= FETCH_PC;
      end else begin
         case (phase_q)
            FETCH_PC:    phase_q <= FETCH_INSTR;
            FETCH_INSTR: if (wb_ack_i) phase_q <= PLACE_SRC1;
            PLACE_SRC1:  phase_q <= PLACE_SRC2;
            PLACE_SRC2:  phase_q <= PLACE_IMM;
            PLACE_IMM:   phase_q <= EXECUTE;
            EXECUTE: begin
               if (eng_done_i) begin
                  phase_q <= (dec_i.load || dec_i.store) ? MEMORY : FETCH_PC;
               end
            end
            MEMORY:      if (wb_ack_i) phase_q <= FETCH_PC;
            default:     phase_q <= FETCH_PC;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (phase_q == FETCH_PC) begin
         adr_q <= reg_a_i;              // RVPC
      end else if (phase_q == EXECUTE && eng_done_i) begin
         adr_q <= eng_result_i;         // rs1 + imm
      end
      if (phase_q == PLACE_SRC2) begin
         st_dat_q <= reg_b_i;
      end
   end

   // ------------------------------------------------------------
   // Register bank ports

   always_comb begin
      reg_ra_o    = micro_reg(RVPC);
      reg_rb_o    = micro_reg(SRC2);
      reg_wa_o    = micro_reg(TMP0);
      reg_we_o    = 1'b0;
      reg_wdata_o = reg_a_i;
      case (phase_q)
         PLACE_SRC1: begin
            reg_ra_o = rv_reg(dec_i.rs1);
            reg_wa_o = micro_reg(SRC1);
            reg_we_o = 1'b1;
         end
         PLACE_SRC2: begin
            reg_rb_o    = rv_reg(dec_i.rs2);
            reg_wa_o    = micro_reg(SRC2);
            reg_we_o    = dec_i.rtype;     // Only ADD and SUB read SRC2
            reg_wdata_o = reg_b_i;
         end
         PLACE_IMM: begin
            reg_wa_o    = micro_reg(IMMI);
            reg_we_o    = 1'b1;
            reg_wdata_o = dec_i.imm;
         end
         EXECUTE: begin
            reg_ra_o = micro_reg(eng_ra_i);   // Engine owns the micro half
            reg_rb_o = micro_reg(eng_rb_i);
            if (eng_wb_en_i) begin
               reg_wa_o    = micro_reg(eng_wb_idx_i);
               reg_we_o    = 1'b1;
               reg_wdata_o = eng_wb_val_i;
            end else if (eng_done_i && dec_i.writes_rd && !dec_i.load) begin
               reg_wa_o    = rv_reg(dec_i.rd);
               reg_we_o    = 1'b1;
               reg_wdata_o = eng_result_i;
            end
         end
         MEMORY: begin
            if (wb_ack_i && dec_i.load && dec_i.writes_rd) begin
               reg_wa_o    = rv_reg(dec_i.rd);
               reg_we_o    = 1'b1;
               reg_wdata_o = wb_dat_i;
            end
         end
         default: ;
      endcase
   end

   assign dec_load_o  = (phase_q == FETCH_INSTR) && wb_ack_i;
   assign eng_start_o = phase_q == PLACE_IMM;

   // ------------------------------------------------------------
   // Wishbone request

   always_comb begin
      wb_o.stb = (phase_q == FETCH_INSTR) || (phase_q == MEMORY);
      wb_o.cyc = wb_o.stb;
      wb_o.we  = (phase_q == MEMORY) && dec_i.store;
      wb_o.sel = 4'hF;
      wb_o.adr = adr_q;
      wb_o.dat = st_dat_q;
   end

   // A pending request holds until the slave acknowledges it
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_o.stb && !wb_ack_i) |=> $stable(wb_o))
      else $error("request changed before ack");

endmodule

`default_nettype wire

// ==== hw/subleq_engine.sv ====
// SUBLEQ sequencer, one micro-op every three cycles: fetch, execute, writeback
// start_i must only arrive while the engine is idle
`timescale 1ns/100ps
`default_nettype none

module subleq_engine
   import oisc_pkg::*;
#(
   parameter int ROM_DEPTH = 256
)(
   input  wire             clk,
   input  wire             rst_n,
   input  wire             start_i,
   input  wire upc_t       entry_i,
   input  wire word_t      a_i,        // Value of ra_o
   input  wire word_t      b_i,        // Value of rb_o
   output micro_idx_t      ra_o,
   output micro_idx_t      rb_o,
   output logic            wb_en_o,
   output micro_idx_t      wb_idx_o,
   output word_t           wb_val_o,
   output logic            done_o,
   output word_t           result_o
);

   upc_t         upc_q;
   micro_phase_e phase_q;
   logic         busy_q;
   micro_op_t    op_q;
   word_t        diff_q;     // b - a of the current op
   logic         last_op;
   logic         in_wb;

   assign last_op = op_q.jump == JUMP_LAST;
   assign in_wb   = busy_q && (phase_q == U_WRITEBACK);

   // ------------------------------------------------------------
   // Sequencing

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q  <= 1'b0;
         phase_q <= U_FETCH;
         upc_q   <= '0;
      end else if (start_i) begin
         busy_q  <= 1'b1;
         phase_q <= U_FETCH;
         upc_q   <= entry_i;
      end else if (busy_q) begin
         case (phase_q)
            U_FETCH: phase_q <= U_EXEC;
            U_EXEC:  phase_q <= U_WRITEBACK;
            U_WRITEBACK: begin
               phase_q <= U_FETCH;
               if (last_op) begin
                  busy_q <= 1'b0;
               end else if ($signed(diff_q) <= 0) begin
                  upc_q <= upc_q + op_q.jump;   // Jump field is two's complement
               end else begin
                  upc_q <= upc_q + 8'd1;
               end
            end
            default: phase_q <= U_FETCH;
         endcase
      end
   end

   // ------------------------------------------------------------
   // ROM read and subtract

   always_ff @(posedge clk) begin
      if (busy_q && phase_q == U_FETCH) begin
         op_q <= rom_word(upc_q);
      end
      if (busy_q && phase_q == U_EXEC) begin
         diff_q <= b_i - a_i;
      end
   end

   assign ra_o     = op_q.a_idx;
   assign rb_o     = op_q.b_idx;
   assign wb_en_o  = in_wb && !last_op;   // Last op leaves b alone
   assign wb_idx_o = op_q.b_idx;
   assign wb_val_o = diff_q;
   assign done_o   = in_wb && last_op;
   assign result_o = diff_q;

   // A runaway routine must not leave the ROM
   a_upc_range: assert property (@(posedge clk) disable iff (!rst_n)
      busy_q |-> (int'(upc_q) < ROM_DEPTH))
      else $error("micro PC out of ROM");

endmodule

`default_nettype wire

// ==== hw/reg_bank.sv ====
// 64 x 32 bank, micro registers at 0-15 and x1..x31 at 33-63
// Indexes 16-32 read zero and ignore writes, so x0 is hard wired
`timescale 1ns/100ps
`default_nettype none

module reg_bank
   import oisc_pkg::*;
(
   input  wire           clk,
   input  wire           rst_n,
   input  wire reg_idx_t ra_i,
   input  wire reg_idx_t rb_i,
   input  wire reg_idx_t wa_i,
   input  wire           we_i,
   input  wire word_t    wdata_i,
   output word_t         a_o,
   output word_t         b_o
);

   word_t regs [64];

   function automatic logic in_use(reg_idx_t idx);
      return (idx < 6'd16) || (idx > 6'd32);
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++) begin
            regs[i] <= '0;
         end
         regs[RVPC] <= RESET_PC;
         regs[ONE]  <= 32'd1;
         regs[NEXT] <= 32'hFFFF_FFFC;   // -4
      end else if (we_i && in_use(wa_i)) begin
         regs[wa_i] <= wdata_i;
      end
   end

   assign a_o = in_use(ra_i) ? regs[ra_i] : '0;
   assign b_o = in_use(rb_i) ? regs[rb_i] : '0;

   // Control must never route a result to x0
   a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
      we_i |-> (wa_i != rv_reg(5'd0)))
      else $error("write to x0");

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
// Instruction latch and field decode; outputs hold until the next load
// funct3 of loads and stores must select a word access
`timescale 1ns/100ps
`default_nettype none

module rv_decoder
   import oisc_pkg::*;
(
   input  wire        clk,
   input  wire        rst_n,
   input  wire word_t instr_i,
   input  wire        load_i,     // Instruction word is valid
   output dec_t       dec_o
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       is_op;
   logic       is_imm;
   logic       is_load;
   logic       is_store;
   logic       supported;
   word_t      imm_i;
   word_t      imm_s;
   dec_t       dec_d;
   dec_t       dec_q;
   logic       supported_q;

   assign opcode   = instr_i[6:0];
   assign funct3   = instr_i[14:12];
   assign is_op    = opcode == OPC_OP;
   assign is_imm   = opcode == OPC_OP_IMM;
   assign is_load  = opcode == OPC_LOAD;
   assign is_store = opcode == OPC_STORE;

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

   // ADD or SUB only, funct7 bit 30 picks SUB
   assign supported =
      (is_op && funct3 == 3'b000 && instr_i[31] == 1'b0 && instr_i[29:25] == 5'd0) ||
      (is_imm && funct3 == 3'b000) ||
      ((is_load || is_store) && funct3 == 3'b010);

   always_comb begin
      dec_d.rs1       = instr_i[19:15];
      dec_d.rs2       = instr_i[24:20];
      dec_d.rd        = instr_i[11:7];
      dec_d.imm       = is_store ? imm_s : imm_i;
      dec_d.entry     = is_op ? (instr_i[30] ? ENTRY_SUB : ENTRY_ADD) : ENTRY_ADDR;
      dec_d.rtype     = is_op;
      dec_d.writes_rd = (is_op || is_imm || is_load) && (instr_i[11:7] != 5'd0);
      dec_d.load      = is_load;
      dec_d.store     = is_store;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_q       <= '0;
         supported_q <= 1'b1;
      end else if (load_i) begin
         dec_q       <= dec_d;
         supported_q <= supported;
      end
   end

   assign dec_o = dec_q;

   // Every fetched instruction must belong to the kept subset
   a_supported: assert property (@(posedge clk) disable iff (!rst_n)
      load_i |=> supported_q)
      else $error("unsupported instruction");

endmodule

`default_nettype wire

// ==== hw/oisc_pkg.sv ====
// Shared widths, register map, micro-op layout and phase encodings of the OISC core
// Only ADD, SUB, ADDI, LW and SW are decoded; all memory accesses are full words
`default_nettype none

package oisc_pkg;

   typedef logic [31:0] word_t;       // Data and address word
   typedef logic [5:0]  reg_idx_t;    // Bank index, RISC-V xn sits at 32 + n
   typedef logic [4:0]  rv_idx_t;     // RISC-V register number
   typedef logic [3:0]  micro_idx_t;  // Micro register number
   typedef logic [7:0]  upc_t;        // Micro program counter

   // ------------------------------------------------------------
   // Micro register map

   localparam micro_idx_t TMP0 = 4'd0;   // Scratch
   localparam micro_idx_t RVPC = 4'd1;   // RISC-V program counter
   localparam micro_idx_t SRC1 = 4'd2;   // Copy of rs1
   localparam micro_idx_t SRC2 = 4'd4;   // Copy of rs2
   localparam micro_idx_t IMMI = 4'd8;   // Decoded immediate
   localparam micro_idx_t ONE  = 4'd10;  // Constant 1
   localparam micro_idx_t NEXT = 4'd13;  // Constant -4

   localparam word_t RESET_PC = 32'h4000_0000;

   // ------------------------------------------------------------
   // Micro-op layout, a in [15:12], b in [11:8], jump in [7:0]

   typedef struct packed {
      micro_idx_t a_idx;   // Subtrahend
      micro_idx_t b_idx;   // Minuend and destination
      logic [7:0] jump;    // Signed upc offset taken when b - a <= 0
   } micro_op_t;

   localparam logic [7:0] JUMP_NEXT = 8'h01;
   localparam logic [7:0] JUMP_LAST = 8'hFF;  // Marks the last op of a routine

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   typedef enum logic [2:0] {
      FETCH_PC,
      FETCH_INSTR,
      PLACE_SRC1,
      PLACE_SRC2,
      PLACE_IMM,
      EXECUTE,
      MEMORY
   } rv_phase_e;

   typedef enum logic [1:0] {
      U_FETCH,
      U_EXEC,
      U_WRITEBACK
   } micro_phase_e;

   typedef struct packed {
      rv_idx_t rs1;
      rv_idx_t rs2;
      rv_idx_t rd;
      word_t   imm;        // I-type, or S-type for stores
      upc_t    entry;      // First micro-op of the routine
      logic    rtype;
      logic    writes_rd;  // Set only when rd is not x0
      logic    load;
      logic    store;
   } dec_t;

   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [3:0] sel;
      word_t      adr;
      word_t      dat;
   } wb_req_t;

   function automatic reg_idx_t rv_reg(rv_idx_t n);
      return {1'b1, n};
   endfunction

   function automatic reg_idx_t micro_reg(micro_idx_t i);
      return {2'b00, i};
   endfunction

   `include "oisc_microcode.svh"

endpackage

`default_nettype wire

// ==== hw/oisc_microcode.svh ====
// Microcode routines for the kept subset; each one advances RVPC by 4
// Words outside the routines read as zero, an op that never ends
`ifndef OISC_MICROCODE_SVH
`define OISC_MICROCODE_SVH

localparam upc_t ENTRY_ADD  = 8'd0;
localparam upc_t ENTRY_SUB  = 8'd4;
localparam upc_t ENTRY_ADDR = 8'd6;   // ADDI, and the LW/SW address

function automatic micro_op_t rom_word(upc_t addr);
   case (addr)
      // ADD, SRC1 + SRC2 as SRC1 - (0 - SRC2)
      ENTRY_ADD:         return '{TMP0, TMP0, JUMP_NEXT};   // Clear TMP0
      ENTRY_ADD + 8'd1:  return '{SRC2, TMP0, JUMP_NEXT};   // TMP0 = -SRC2
      ENTRY_ADD + 8'd2:  return '{NEXT, RVPC, JUMP_NEXT};   // PC + 4
      ENTRY_ADD + 8'd3:  return '{TMP0, SRC1, JUMP_LAST};

      // SUB
      ENTRY_SUB:         return '{NEXT, RVPC, JUMP_NEXT};
      ENTRY_SUB + 8'd1:  return '{SRC2, SRC1, JUMP_LAST};

      // Address add, SRC1 + IMMI
      ENTRY_ADDR:        return '{TMP0, TMP0, JUMP_NEXT};
      ENTRY_ADDR + 8'd1: return '{IMMI, TMP0, JUMP_NEXT};
      ENTRY_ADDR + 8'd2: return '{NEXT, RVPC, JUMP_NEXT};
      ENTRY_ADDR + 8'd3: return '{TMP0, SRC1, JUMP_LAST};

      default:           return '0;
   endcase
endfunction

`endif
